// File: verif/shader_vectors.txt
# cmd a b, hex fields: I inst addr word, D data addr word, R budget exception
# C data addr expected word, T closes the test; text after the fields is a note
I 00 18400064 arithmetic: addi r1,r0,100
I 04 18803FF9 addi r2,r0,-7
I 08 04C48000 add r3,r1,r2
I 0C 09048000 sub r4,r1,r2
I 10 0D448000 and r5,r1,r2
I 14 11848000 or r6,r1,r2
I 18 15C48000 xor r7,r1,r2
I 1C 2000C000 store r3,0(r0)
I 20 20010004 store r4,4(r0)
I 24 20014008 store r5,8(r0)
I 28 2001800C store r6,12(r0)
I 2C 2001C010 store r7,16(r0)
I 30 FC000000 halt
R 0D 0
C 00 0000005D 100 + -7
C 04 0000006B 100 - -7
C 08 00000060
C 0C FFFFFFFD
C 10 FFFFFF9D
T
D 40 00001234 load/store: preloads
D 44 0000ABCD
D 48 CAFEF00D never touched
I 00 1C400040 load r1,0x40(r0)
I 04 1C800044 load r2,0x44(r0)
I 08 04C48000 add r3,r1,r2
I 0C 2000C050 store r3,0x50(r0)
I 10 20004054 store r1,0x54(r0)
I 14 FC000000 halt
R 06 0
C 50 0000BE01
C 54 00001234
C 40 00001234
C 48 CAFEF00D
T
I 00 18400001 branch loop: addi r1,r0,1
I 04 18C0000B addi r3,r0,11
I 08 04884000 add r2,r2,r1
I 0C 18440001 addi r1,r1,1
I 10 2404C001 beq r1,r3,+1 leaves the loop
I 14 24003FFC beq r0,r0,-4 back to 0x08
I 18 20008060 store r2,0x60(r0)
I 1C FC000000 halt
R 2B 0
C 60 00000037 sum of 1 to 10
T
D 70 00000000 illegal opcode
D 74 55555555
I 00 18400011 addi r1,r0,0x11
I 04 20004070 store r1,0x70(r0)
I 08 28000000 opcode 0x0a is illegal
I 0C 20004074 store r1,0x74(r0) never runs
I 10 FC000000 halt
R 03 1
C 70 00000011
C 74 55555555
T
D 80 A5A5A5A5 misaligned store
I 00 18400022 addi r1,r0,0x22
I 04 20004082 store r1,0x82(r0)
I 08 FC000000 halt
R 02 1
C 80 A5A5A5A5
T
I 00 18400033 rerun over old contents: addi r1,r0,0x33
I 04 20004080 store r1,0x80(r0)
I 08 FC000000 halt
R 03 0
C 80 00000033
C 70 00000011 left from the illegal opcode test
T

// File: shader.f
hdl/shader_isa_pkg.sv
hdl/shader_mem_pkg.sv
hdl/ram_port_if.sv
hdl/block_ram.sv
hdl/core_ctrl_fsm.sv
hdl/program_counter.sv
hdl/exec_unit.sv
hdl/shader_top.sv
verif/shader_asserts.sv
verif/shader_tb.sv

// File: verif/shader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module shader_tb
    import shader_mem_pkg::*;
();

    localparam string VECTOR_FILE = "verif/shader_vectors.txt";

    logic  clock;
    logic  rst;
    logic  run;
    logic  ext_enable_write_inst;
    logic  ext_enable_write_data;
    addr_t ext_address;
    word_t ext_write_data;
    logic  halted;
    logic  exception;
    word_t ext_read_data;

    byte   cmd_q[$];            // one entry per vector line
    word_t field_a_q[$];
    word_t field_b_q[$];
    int    cycle_count = 0;
    int    cycle_limit;
    int    test_num;
    logic  test_open;

    shader_top dut0 (
        .clock                 (clock),
        .rst                   (rst),
        .run                   (run),
        .ext_enable_write_inst (ext_enable_write_inst),
        .ext_enable_write_data (ext_enable_write_data),
        .ext_address           (ext_address),
        .ext_write_data        (ext_write_data),
        .halted                (halted),
        .exception             (exception),
        .ext_read_data         (ext_read_data)
    );

    always #20 clock = ~clock;   // 40 ns period

    // watchdog and FSM assertion monitor
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (dut0.ctrl.fsm_checks.fail_count != 0) begin
            $display("an assertion on the control FSM failed");
            abort_run();
        end else if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_count);
            abort_run();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // checking
    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // vector file
    task automatic read_vectors();
        int    fd;
        int    n;
        string line;
        byte   cmd;
        word_t field_a;
        word_t field_b;
        logic  ok;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %s", VECTOR_FILE);
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r") begin
                continue;                               // comment or blank line
            end
            field_a = '0;
            field_b = '0;
            n = $sscanf(line, "%c %h %h", cmd, field_a, field_b);
            case (cmd)
                "I", "D", "C", "R": ok = (n == 3);
                "T":                ok = 1'b1;
                default:            ok = 1'b0;
            endcase
            if (!ok) begin
                $display("malformed line in the vector file: %s", line);
                abort_run();
            end
            cmd_q.push_back(cmd);
            field_a_q.push_back(field_a);
            field_b_q.push_back(field_b);
        end
        $fclose(fd);
    endtask

    // worst case cycles for the whole file
    function automatic int cycle_budget();
        int total;
        total = 100;                                    // margin
        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "I", "D": total += 1;                   // one write each
                "C":      total += 2;                   // address then data
                "R":      total += 5 * int'(field_a_q[i]);
                "T":      total += 8;                   // reset pulse and run hand-off
                default:  ;
            endcase
        end
        return total;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // bus actions
    task automatic pulse_reset();
        @(posedge clock);
        rst                   <= 1'b1;
        run                   <= 1'b0;
        ext_enable_write_inst <= 1'b0;
        ext_enable_write_data <= 1'b0;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        check_flag("halted", 1'b0, halted);
        check_flag("exception", 1'b0, exception);
    endtask

    task automatic write_word(input logic to_inst, input addr_t address, input word_t data);
        @(posedge clock);
        ext_enable_write_inst <= to_inst;
        ext_enable_write_data <= !to_inst;
        ext_address           <= address;
        ext_write_data        <= data;
    endtask

    task automatic run_program(input int budget, input logic expected_exc);
        int waited;
        @(posedge clock);
        ext_enable_write_inst <= 1'b0;
        ext_enable_write_data <= 1'b0;
        run                   <= 1'b1;
        waited = 0;
        @(negedge clock);
        while (halted !== 1'b1) begin
            if (waited > 5 * budget) begin
                $display("test %0d did not halt within %0d instructions", test_num, budget);
                abort_run();
            end
            waited++;
            @(negedge clock);
        end
        @(posedge clock);
        run <= 1'b0;                                    // flags must survive this
        @(negedge clock);
        check_flag("halted", 1'b1, halted);
        check_flag("exception", expected_exc, exception);
    endtask

    task automatic read_back(input addr_t address, input word_t expected);
        @(posedge clock);
        ext_address <= address;
        @(posedge clock);                               // registered RAM read
        @(negedge clock);
        check_word($sformatf("ext_read_data[%h]", address), expected, ext_read_data);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // main sequence
    initial begin
        clock                 = 1'b0;
        rst                   = 1'b1;
        run                   = 1'b0;
        ext_enable_write_inst = 1'b0;
        ext_enable_write_data = 1'b0;
        ext_address           = '0;
        ext_write_data        = '0;
        test_num              = 0;
        test_open             = 1'b0;

        read_vectors();
        cycle_limit = cycle_budget();

        foreach (cmd_q[i]) begin
            if (!test_open && cmd_q[i] != "T") begin
                test_num++;
                test_open = 1'b1;
                pulse_reset();                          // every test starts clean
            end
            case (cmd_q[i])
                "I": write_word(1'b1, addr_t'(field_a_q[i]), field_b_q[i]);
                "D": write_word(1'b0, addr_t'(field_a_q[i]), field_b_q[i]);
                "R": run_program(int'(field_a_q[i]), field_b_q[i][0]);
                "C": read_back(addr_t'(field_a_q[i]), field_b_q[i]);
                "T": test_open = 1'b0;
                default: ;
            endcase
        end

        if (test_num == 0) begin
            $display("the vector file holds no tests");
            abort_run();
        end else if (dut0.ctrl.fsm_checks.fail_count != 0) begin
            $display("%0d assertion failures in the control FSM",
                     dut0.ctrl.fsm_checks.fail_count);
            abort_run();
        end else begin
            $display("%0d tests completed", test_num);
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verif/shader_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module shader_asserts
    import shader_isa_pkg::*;
(
    input wire logic        clock,
    input wire logic        rst,
    input wire core_state_e state,
    input wire logic        halted,
    input wire logic        exception,
    input wire logic        mem_write
);

    int fail_count = 0;   // failed assertions so far

    // ~~~~~~~~~~~~~~~~~~~~
    // control FSM rules
    halted_held: assert property (@(posedge clock) disable iff (rst) halted |=> halted)
        else begin
            fail_count++;
            $error("halted dropped without rst");
        end

    exception_halts: assert property (@(posedge clock) disable iff (rst) exception |-> halted)
        else begin
            fail_count++;
            $error("exception high while halted is low");
        end

    store_in_mem: assert property (@(posedge clock) disable iff (rst) mem_write |-> state == MEM)
        else begin
            fail_count++;
            $error("mem_write outside the MEM state");
        end

    state_known: assert property (@(posedge clock) disable iff (rst) !$isunknown(state))
        else begin
            fail_count++;
            $error("FSM state is unknown");
        end

endmodule

bind core_ctrl_fsm shader_asserts fsm_checks (
    .clock     (clock),
    .rst       (rst),
    .state     (state),
    .halted    (halted),
    .exception (exception),
    .mem_write (mem_write)
);

`default_nettype wire

// File: hdl/shader_top.sv
`timescale 1ns/1ps
`default_nettype none

module shader_top
    import shader_isa_pkg::*, shader_mem_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  rst,
    input  wire logic  run,                    // low to load and read back
    input  wire logic  ext_enable_write_inst,
    input  wire logic  ext_enable_write_data,
    input  wire addr_t ext_address,
    input  wire word_t ext_write_data,
    output logic       halted,
    output logic       exception,
    output word_t      ext_read_data           // data word, one clock after address
);

    ram_port_if core_inst_bus ();
    ram_port_if core_data_bus ();
    ram_port_if inst_bus ();
    ram_port_if data_bus ();

    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    imm_t     imm;
    logic     branch_taken;
    logic     misaligned;
    logic     pc_advance;
    logic     pc_branch;
    logic     reg_write;
    logic     mem_write;

    // ~~~~~~~~~~~~~~~~~~~~
    // RAM port multiplexing
    always_comb begin
        if (run) begin
            inst_bus.address    = core_inst_bus.address;
            inst_bus.write      = core_inst_bus.write;
            inst_bus.write_data = core_inst_bus.write_data;
            data_bus.address    = core_data_bus.address;
            data_bus.write      = core_data_bus.write;
            data_bus.write_data = core_data_bus.write_data;
        end else begin
            inst_bus.address    = ext_address;
            inst_bus.write      = ext_enable_write_inst;
            inst_bus.write_data = ext_write_data;
            data_bus.address    = ext_address;
            data_bus.write      = ext_enable_write_data;
            data_bus.write_data = ext_write_data;
        end
    end

    assign core_inst_bus.read_data = inst_bus.read_data;
    assign core_data_bus.read_data = data_bus.read_data;
    assign ext_read_data           = data_bus.read_data;

    block_ram inst_ram (.clock(clock), .bus(inst_bus));
    block_ram data_ram (.clock(clock), .bus(data_bus));

    // ~~~~~~~~~~~~~~~~~~~~
    // core
    core_ctrl_fsm ctrl (
        .clock        (clock),
        .rst          (rst),
        .run          (run),
        .instr        (core_inst_bus.read_data),
        .branch_taken (branch_taken),
        .misaligned   (misaligned),
        .opcode       (opcode),
        .rd           (rd),
        .rs           (rs),
        .rt           (rt),
        .imm          (imm),
        .pc_advance   (pc_advance),
        .pc_branch    (pc_branch),
        .reg_write    (reg_write),
        .mem_write    (mem_write),
        .halted       (halted),
        .exception    (exception)
    );

    program_counter pc0 (
        .clock      (clock),
        .rst        (rst),
        .pc_advance (pc_advance),
        .pc_branch  (pc_branch),
        .imm        (imm),
        .inst_bus   (core_inst_bus)
    );

    exec_unit exec0 (
        .clock        (clock),
        .rst          (rst),
        .opcode       (opcode),
        .rd           (rd),
        .rs           (rs),
        .rt           (rt),
        .imm          (imm),
        .reg_write    (reg_write),
        .mem_write    (mem_write),
        .branch_taken (branch_taken),
        .misaligned   (misaligned),
        .data_bus     (core_data_bus)
    );

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import shader_isa_pkg::*, shader_mem_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      rst,
    input  wire opcode_e   opcode,
    input  wire reg_idx_t  rd,
    input  wire reg_idx_t  rs,
    input  wire reg_idx_t  rt,
    input  wire imm_t      imm,
    input  wire logic      reg_write,
    input  wire logic      mem_write,
    output logic           branch_taken,
    output logic           misaligned,
    ram_port_if.requester  data_bus
);

    word_t regs [NUM_REGS];
    word_t rs_val;
    word_t rt_val;
    word_t imm_ext;
    word_t rs_plus_imm;    // ADDI result and data address
    word_t alu_result;
    word_t rd_data;

    // ~~~~~~~~~~~~~~~~~~~~
    // register file
    assign rs_val = (rs == '0) ? '0 : regs[rs];   // r0 fixed at zero
    assign rt_val = (rt == '0) ? '0 : regs[rt];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU
    assign imm_ext     = {{(WORD_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
    assign rs_plus_imm = rs_val + imm_ext;

    always_comb begin
        case (opcode)
            OP_ADD:  alu_result = rs_val + rt_val;
            OP_SUB:  alu_result = rs_val - rt_val;
            OP_AND:  alu_result = rs_val & rt_val;
            OP_OR:   alu_result = rs_val | rt_val;
            OP_XOR:  alu_result = rs_val ^ rt_val;
            OP_ADDI: alu_result = rs_plus_imm;
            default: alu_result = '0;
        endcase
    end

    assign rd_data      = (opcode == OP_LOAD) ? data_bus.read_data : alu_result;
    assign branch_taken = (opcode == OP_BEQ) && (rs_val == rt_val);

    // ~~~~~~~~~~~~~~~~~~~~
    // data access
    assign data_bus.address    = rs_plus_imm[ADDRESS_WIDTH-1:0];
    assign data_bus.write      = mem_write;
    assign data_bus.write_data = rt_val;             // store data
    assign misaligned          = |rs_plus_imm[1:0];  // word accesses only

endmodule

`default_nettype wire

// File: hdl/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter
    import shader_isa_pkg::*, shader_mem_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      rst,
    input  wire logic      pc_advance,
    input  wire logic      pc_branch,
    input  wire imm_t      imm,
    ram_port_if.requester  inst_bus
);

    addr_t pc;
    addr_t next_seq;      // address of the next instruction
    addr_t branch_offset;

    assign next_seq = pc + addr_t'(4);

    // signed word offset scaled to bytes
    assign branch_offset = {{(ADDRESS_WIDTH-IMM_WIDTH-2){imm[IMM_WIDTH-1]}}, imm, 2'b00};

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_branch) begin
            pc <= next_seq + branch_offset;
        end else if (pc_advance) begin
            pc <= next_seq;
        end
    end

    // fetch only, the inst RAM is never written by the core
    assign inst_bus.address    = pc;
    assign inst_bus.write      = 1'b0;
    assign inst_bus.write_data = '0;

endmodule

`default_nettype wire

// File: hdl/core_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_fsm
    import shader_isa_pkg::*, shader_mem_pkg::*;
(
    input  wire logic clock,
    input  wire logic rst,
    input  wire logic run,
    input  wire word_t instr,         // inst RAM read data
    input  wire logic branch_taken,
    input  wire logic misaligned,
    output opcode_e   opcode,
    output reg_idx_t  rd,
    output reg_idx_t  rs,
    output reg_idx_t  rt,
    output imm_t      imm,
    output logic      pc_advance,
    output logic      pc_branch,
    output logic      reg_write,
    output logic      mem_write,
    output logic      halted,
    output logic      exception
);

    core_state_e state;
    word_t       ir;             // instruction register
    opcode_e     fetched_op;
    logic        fetched_legal;
    logic        is_alu_op;
    logic        is_mem_op;

    // ~~~~~~~~~~~~~~~~~~~~
    // decode
    assign fetched_op = opcode_e'(instr[OPCODE_LSB +: OPCODE_WIDTH]);

    always_comb begin
        case (fetched_op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI,
            OP_LOAD, OP_STORE, OP_BEQ, OP_HALT: fetched_legal = 1'b1;
            default:                            fetched_legal = 1'b0;
        endcase
    end

    assign opcode = opcode_e'(ir[OPCODE_LSB +: OPCODE_WIDTH]);
    assign rd     = ir[RD_LSB +: REG_FIELD_WIDTH];
    assign rs     = ir[RS_LSB +: REG_FIELD_WIDTH];
    assign rt     = ir[RT_LSB +: REG_FIELD_WIDTH];
    assign imm    = ir[IMM_LSB +: IMM_WIDTH];

    assign is_alu_op = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};
    assign is_mem_op = opcode inside {OP_LOAD, OP_STORE};

    // ~~~~~~~~~~~~~~~~~~~~
    // sequencing
    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= IDLE;
            halted    <= 1'b0;
            exception <= 1'b0;
        end else begin
            case (state)
                IDLE:    if (run) state <= FETCH;
                FETCH:   state <= DECODE;            // PC on inst RAM address
                DECODE: begin
                    ir <= instr;
                    if (!fetched_legal) begin
                        state     <= HALTED;
                        halted    <= 1'b1;
                        exception <= 1'b1;
                    end else begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (opcode == OP_HALT) begin
                        state  <= HALTED;
                        halted <= 1'b1;
                    end else if (is_mem_op && misaligned) begin
                        state     <= HALTED;         // nothing written
                        halted    <= 1'b1;
                        exception <= 1'b1;
                    end else if (is_mem_op) begin
                        state <= MEM;
                    end else begin
                        state <= FETCH;
                    end
                end
                MEM:     state <= FETCH;
                HALTED:  state <= HALTED;            // only rst leaves
                default: state <= IDLE;
            endcase
        end
    end

    // strobes, one set per instruction
    assign reg_write  = (state == EXECUTE && is_alu_op) ||
                        (state == MEM && opcode == OP_LOAD);
    assign mem_write  = state == MEM && opcode == OP_STORE;
    assign pc_branch  = state == EXECUTE && opcode == OP_BEQ && branch_taken;
    assign pc_advance = (state == EXECUTE && (is_alu_op || (opcode == OP_BEQ && !branch_taken))) ||
                        state == MEM;

endmodule

`default_nettype wire

// File: hdl/block_ram.sv
`timescale 1ns/1ps
`default_nettype none

module block_ram
    import shader_mem_pkg::*;
(
    input wire logic clock,
    ram_port_if.ram  bus
);

    localparam int RAM_DEPTH = 2 ** RAM_DEPTH_LOG2;

    word_t mem [RAM_DEPTH];
    logic [RAM_DEPTH_LOG2-1:0] word_index;

    // byte address to word index, low two bits dropped
    assign word_index = bus.address[RAM_DEPTH_LOG2+1:2];

    always_ff @(posedge clock) begin
        if (bus.write) begin
            mem[word_index] <= bus.write_data;
        end
        bus.read_data <= mem[word_index];   // old word on a write cycle
    end

endmodule

`default_nettype wire

// File: hdl/ram_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ram_port_if
    import shader_mem_pkg::*;
();

    addr_t address;     // byte address
    logic  write;       // write strobe
    word_t write_data;
    word_t read_data;   // valid one clock after address

    modport requester (
        output address,
        output write,
        output write_data,
        input  read_data
    );

    modport ram (
        input  address,
        input  write,
        input  write_data,
        output read_data
    );

endinterface

`default_nettype wire

// File: hdl/shader_mem_pkg.sv
`default_nettype none

package shader_mem_pkg;

    localparam int WORD_WIDTH     = 32;
    localparam int ADDRESS_WIDTH  = 16;  // byte address
    localparam int RAM_DEPTH_LOG2 = 8;   // 256 words per RAM

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADDRESS_WIDTH-1:0] addr_t;

endpackage

`default_nettype wire

// File: hdl/shader_isa_pkg.sv
`default_nettype none

package shader_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // instruction fields
    localparam int OPCODE_WIDTH    = 6;
    localparam int OPCODE_LSB      = 26;   // opcode in bits 31:26
    localparam int REG_FIELD_WIDTH = 4;
    localparam int RD_LSB          = 22;   // rd in bits 25:22
    localparam int RS_LSB          = 18;   // rs in bits 21:18
    localparam int RT_LSB          = 14;   // rt in bits 17:14
    localparam int IMM_WIDTH       = 14;
    localparam int IMM_LSB         = 0;    // signed immediate in bits 13:0
    localparam int NUM_REGS        = 16;   // r0 reads as zero

    typedef logic [REG_FIELD_WIDTH-1:0] reg_idx_t;
    typedef logic signed [IMM_WIDTH-1:0] imm_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // operations, any other code is illegal
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_ADD   = 6'h01,
        OP_SUB   = 6'h02,
        OP_AND   = 6'h03,
        OP_OR    = 6'h04,
        OP_XOR   = 6'h05,
        OP_ADDI  = 6'h06,
        OP_LOAD  = 6'h07,
        OP_STORE = 6'h08,
        OP_BEQ   = 6'h09,
        OP_HALT  = 6'h3f
    } opcode_e;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        FETCH   = 3'd1,
        DECODE  = 3'd2,
        EXECUTE = 3'd3,
        MEM     = 3'd4,
        HALTED  = 3'd5
    } core_state_e;

endpackage

`default_nettype wire
